/* baud_timer.sv */
// bit period counter
// ticks every CLKS_PER_BIT clocks while run is high, half makes the
// first period half a bit long for mid-bit sampling
module baud_timer #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic run,
	input  logic half,
	output logic tick
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);
	// preload so that only CLKS_PER_BIT/2 counts remain before the first tick
	localparam logic [CW-1:0] HALF_START = CW'(CLKS_PER_BIT - CLKS_PER_BIT / 2);

	logic [CW-1:0] cnt;

	assign tick = run && (cnt == LAST);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else if (!run) begin
			cnt <= half ? HALF_START : '0;
		end else if (tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// counter wraps at the bit boundary
	a_cnt_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		cnt < CLKS_PER_BIT
	) else $error("baud_timer count out of range");

endmodule

/* frame_rx_parser.sv */
// frame receive parser
// hunts for a mark pair, collects content up to the closing pair and
// publishes string and length, or flags an overflow
module frame_rx_parser
	import uart_frame_pkg::*;
#(
	parameter int MAX_CHARS = 16
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  byte_t                  rx_byte,
	input  logic                   rx_byte_valid,
	output logic [MAX_CHARS*8-1:0] rx_string,
	output len_t                   rx_length,
	output logic                   rx_busy,
	output logic                   rx_done,
	output logic                   rx_err
);

	rx_state_t             state;
	byte_t [MAX_CHARS-1:0] work_buf;
	len_t                  cnt;
	logic                  is_mark;
	logic                  room1;
	logic                  room2;

	assign is_mark = (rx_byte == FRAME_MARK);
	// space for one byte, or for a pending mark plus one byte
	assign room1   = int'(cnt) < MAX_CHARS;
	assign room2   = int'(cnt) + 2 <= MAX_CHARS;
	assign rx_busy = (state == RX_BODY) || (state == RX_MARK);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= RX_HUNT;
			cnt       <= '0;
			rx_done   <= 1'b0;
			rx_err    <= 1'b0;
			rx_string <= '0;
			rx_length <= '0;
		end else begin
			rx_done <= 1'b0;
			rx_err  <= 1'b0;
			if (rx_byte_valid) begin
				case (state)
					RX_HUNT: if (is_mark) state <= RX_OPEN;
					RX_OPEN: begin
						state <= is_mark ? RX_BODY : RX_HUNT;
						cnt   <= '0;
					end
					RX_BODY: begin
						if (is_mark) begin
							state <= RX_MARK;
						end else if (!room1) begin
							rx_err <= 1'b1;
							state  <= RX_HUNT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					RX_MARK: begin
						if (is_mark) begin
							// closing pair
							rx_string <= work_buf;
							rx_length <= cnt;
							rx_done   <= 1'b1;
							state     <= RX_HUNT;
						end else if (!room2) begin
							rx_err <= 1'b1;
							state  <= RX_HUNT;
						end else begin
							cnt   <= cnt + 2'd2;
							state <= RX_BODY;
						end
					end
					default: state <= RX_HUNT;
				endcase
			end
		end
	end

	// working buffer, a lone mark is kept as content
	always_ff @(posedge sys_clk) begin
		if (rx_byte_valid && !is_mark) begin
			if (state == RX_BODY && room1) begin
				work_buf[cnt] <= rx_byte;
			end else if (state == RX_MARK && room2) begin
				work_buf[cnt]        <= FRAME_MARK;
				work_buf[cnt + 1'b1] <= rx_byte;
			end
		end
	end

	a_cnt_bound: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		cnt <= MAX_CHARS
	) else $error("frame_rx_parser count above MAX_CHARS");

endmodule

/* frame_tx_fsm.sv */
// frame transmit sequencer
// sends two marks, the content bytes from index 0 and two closing marks,
// one byte per serializer done
module frame_tx_fsm
	import uart_frame_pkg::*;
#(
	parameter int MAX_CHARS = 16
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic [MAX_CHARS*8-1:0] tx_string,
	input  len_t                   tx_length,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,
	uart_byte_if.ctrl              bus
);

	tx_state_t             state;
	byte_t [MAX_CHARS-1:0] str_q;
	len_t                  len_q;
	len_t                  idx;

	assign tx_busy = (state != TX_IDLE) && (state != TX_FINISH);
	assign tx_done = (state == TX_FINISH);

	// content byte in the body, a mark everywhere else
	assign bus.data = (state == TX_BODY) ? str_q[idx] : FRAME_MARK;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= TX_IDLE;
			idx       <= '0;
			bus.start <= 1'b0;
		end else begin
			bus.start <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (tx_req) begin
						state     <= TX_OPEN1;
						bus.start <= 1'b1;
					end
				end
				TX_OPEN1: begin
					if (bus.done) begin
						state     <= TX_OPEN2;
						bus.start <= 1'b1;
					end
				end
				TX_OPEN2: begin
					if (bus.done) begin
						// empty string goes straight to the closing marks
						state     <= (len_q == '0) ? TX_CLOSE1 : TX_BODY;
						idx       <= '0;
						bus.start <= 1'b1;
					end
				end
				TX_BODY: begin
					if (bus.done) begin
						if (len_t'(idx + 1'b1) == len_q) begin
							state <= TX_CLOSE1;
						end else begin
							idx <= idx + 1'b1;
						end
						bus.start <= 1'b1;
					end
				end
				TX_CLOSE1: begin
					if (bus.done) begin
						state     <= TX_CLOSE2;
						bus.start <= 1'b1;
					end
				end
				TX_CLOSE2: if (bus.done) state <= TX_FINISH;
				TX_FINISH: state <= TX_IDLE;
				default:   state <= TX_IDLE;
			endcase
		end
	end

	// request captured once, held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_req) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
	end

	a_len_fits: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(state != TX_IDLE) |-> (len_q <= MAX_CHARS)
	) else $error("frame_tx_fsm length above MAX_CHARS");

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the uart string testbench with verilator
verilator --binary --timing --assert -Wno-fatal -f uart_string.f \
	--top-module uart_string_tb -o uart_string_sim || { echo "build failed"; exit 1; }
./obj_dir/uart_string_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

/* uart_byte_if.sv */
// transmit byte path between the frame sequencer and the serializer
// start is a single-cycle request, done pulses at the end of the stop bit
interface uart_byte_if
	import uart_frame_pkg::*;
();

	byte_t data;
	logic  start;
	logic  busy;
	logic  done;

	// frame sequencer side
	modport ctrl (
		output data,
		output start,
		input  busy,
		input  done
	);

	// serializer side
	modport ser (
		input  data,
		input  start,
		output busy,
		output done
	);

endinterface

/* uart_frame_pkg.sv */
// uart string transceiver shared definitions
// character and length types, frame marker, state encodings
package uart_frame_pkg;

	// one character on the serial line
	typedef logic [7:0] byte_t;

	// character count of a string, up to 255
	typedef logic [7:0] len_t;

	// ampersand, sent in pairs around the content
	localparam byte_t FRAME_MARK = 8'h26;

	// frame transmit sequencer
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN1,
		TX_OPEN2,
		TX_BODY,
		TX_CLOSE1,
		TX_CLOSE2,
		TX_FINISH
	} tx_state_t;

	// frame receive parser, RX_MARK holds one pending ampersand
	typedef enum logic [1:0] {
		RX_HUNT,
		RX_OPEN,
		RX_BODY,
		RX_MARK
	} rx_state_t;

	// bit level state of the serializer and deserializer
	typedef enum logic [1:0] {
		BIT_IDLE,
		BIT_START,
		BIT_DATA,
		BIT_STOP
	} uart_bit_state_t;

endpackage

/* uart_rx.sv */
// 8N1 deserializer
// two-flop synchronizer, falling edge detect, start bit recheck at
// mid-bit, data sampled at mid-bit, byte dropped on a low stop bit
module uart_rx
	import uart_frame_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic  sys_clk,
	input  logic  sys_rst_n,
	input  logic  rx,
	output byte_t rx_byte,
	output logic  rx_byte_valid
);

	uart_bit_state_t state;
	logic            rx_s1;
	logic            rx_s2;
	logic            rx_prev;
	logic            fall;
	byte_t           shreg;
	logic [2:0]      bit_idx;
	logic            tick;

	// half period first, so every tick lands mid-bit
	baud_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_baud_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (state != BIT_IDLE),
		.half      (1'b1),
		.tick      (tick)
	);

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1   <= 1'b1;
			rx_s2   <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_s1   <= rx;
			rx_s2   <= rx_s1;
			rx_prev <= rx_s2;
		end
	end

	assign fall = rx_prev && !rx_s2;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= BIT_IDLE;
			bit_idx       <= '0;
			rx_byte_valid <= 1'b0;
		end else begin
			rx_byte_valid <= 1'b0;
			case (state)
				BIT_IDLE: if (fall) state <= BIT_START;
				BIT_START: begin
					// high again at mid-bit means a glitch
					if (tick) begin
						state   <= rx_s2 ? BIT_IDLE : BIT_DATA;
						bit_idx <= '0;
					end
				end
				BIT_DATA: begin
					if (tick) begin
						if (bit_idx == 3'd7) state <= BIT_STOP;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				BIT_STOP: begin
					if (tick) begin
						state         <= BIT_IDLE;
						rx_byte_valid <= rx_s2;
					end
				end
				default: state <= BIT_IDLE;
			endcase
		end
	end

	// data path, bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (state == BIT_DATA && tick) shreg <= {rx_s2, shreg[7:1]};
		if (state == BIT_STOP && tick && rx_s2) rx_byte <= shreg;
	end

endmodule

/* uart_string.f */
uart_frame_pkg.sv
uart_byte_if.sv
baud_timer.sv
uart_tx.sv
uart_rx.sv
frame_tx_fsm.sv
frame_rx_parser.sv
uart_string_top.sv
uart_string_tb.sv

/* uart_string_tb.sv */
// testbench for the uart string transceiver
// drives random frames from an lfsr in both directions, decodes the
// transmit line and checks received frames against a byte level parser model
module uart_string_tb;

	localparam int CLKS_PER_BIT = 16;
	localparam int MAX_CHARS    = 16;
	localparam int SW           = MAX_CHARS * 8;
	localparam logic [7:0] MARK = 8'h26;

	// parser model states
	localparam int M_HUNT = 0;
	localparam int M_OPEN = 1;
	localparam int M_BODY = 2;
	localparam int M_MARK = 3;

	logic          sys_clk;
	logic          sys_rst_n;
	logic [SW-1:0] tx_string;
	logic [7:0]    tx_length;
	logic          tx_req;
	logic          tx_busy;
	logic          tx_done;
	logic [SW-1:0] rx_string;
	logic [7:0]    rx_length;
	logic          rx_busy;
	logic          rx_done;
	logic          rx_err;
	logic          uart_rx_port;
	logic          uart_tx_port;

	logic [31:0]   lfsr_reg = 32'h3078;

	// bytes waiting for the serial driver
	logic [7:0]    line_q[$];

	// parser model and its expected events
	// kind 1 means rx_done and kind 0 means rx_err
	int            m_state = M_HUNT;
	int            m_cnt = 0;
	logic [SW-1:0] m_buf = '0;
	bit            exp_kind[$];
	int            exp_len[$];
	logic [SW-1:0] exp_str[$];

	// last published string that must hold until the next rx_done
	int            last_len = 0;
	logic [SW-1:0] last_str = '0;

	// rx_busy one cycle earlier
	logic          prev_rx_busy = 1'b0;

	uart_string_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MAX_CHARS    (MAX_CHARS)
	) i_uart_string_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic flag_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic timeout_abort(input string what);
		$display("Timed out at %0t while waiting: %s", $time, what);
		abort_run();
	endtask

	// fibonacci lfsr with taps 32 22 2 1
	function logic lfsr_step();
		logic fb;
		fb = lfsr_reg[31] ^ lfsr_reg[21] ^ lfsr_reg[1] ^ lfsr_reg[0];
		lfsr_reg = {lfsr_reg[30:0], fb};
		return fb;
	endfunction

	function logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	function logic [7:0] plain_char();
		logic [7:0] c;
		c = 8'(random_bits(8));
		if (c == MARK) c = 8'h41;
		return c;
	endfunction

	function automatic bit lanes_match(input logic [SW-1:0] a, input logic [SW-1:0] b,
			input int n);
		int i;
		lanes_match = 1'b1;
		for (i = 0; i < n; i++) begin
			if (a[i*8 +: 8] !== b[i*8 +: 8]) lanes_match = 1'b0;
		end
	endfunction

	// framing rules of the receive side applied one byte at a time
	task automatic model_rx_byte(input logic [7:0] b);
		if (m_state == M_HUNT) begin
			if (b == MARK) m_state = M_OPEN;
		end else if (m_state == M_OPEN) begin
			m_state = (b == MARK) ? M_BODY : M_HUNT;
			m_cnt = 0;
		end else if (m_state == M_BODY) begin
			if (b == MARK) begin
				m_state = M_MARK;
			end else if (m_cnt + 1 > MAX_CHARS) begin
				exp_kind.push_back(1'b0);
				exp_len.push_back(0);
				exp_str.push_back('0);
				m_state = M_HUNT;
			end else begin
				m_buf[m_cnt*8 +: 8] = b;
				m_cnt++;
			end
		end else begin
			if (b == MARK) begin
				exp_kind.push_back(1'b1);
				exp_len.push_back(m_cnt);
				exp_str.push_back(m_buf);
				m_state = M_HUNT;
			end else if (m_cnt + 2 > MAX_CHARS) begin
				exp_kind.push_back(1'b0);
				exp_len.push_back(0);
				exp_str.push_back('0);
				m_state = M_HUNT;
			end else begin
				// pending mark was content
				m_buf[m_cnt*8 +: 8] = MARK;
				m_buf[(m_cnt+1)*8 +: 8] = b;
				m_cnt += 2;
				m_state = M_BODY;
			end
		end
	endtask

	// random plain bytes and sometimes a lone mark with a plain byte after it
	task automatic add_garbage();
		int n;
		int i;
		n = int'(random_bits(2));
		for (i = 0; i < n; i++) begin
			line_q.push_back(plain_char());
		end
		if (random_bits(1) == 1) begin
			line_q.push_back(MARK);
			line_q.push_back(plain_char());
		end
	endtask

	task automatic add_frame(input int n);
		logic [7:0] c;
		bit         prev_mark;
		int         i;
		prev_mark = 1'b0;
		line_q.push_back(MARK);
		line_q.push_back(MARK);
		for (i = 0; i < n; i++) begin
			// single marks only between two plain characters
			if (i > 0 && i < n - 1 && !prev_mark && random_bits(2) == 0) begin
				c = MARK;
			end else begin
				c = plain_char();
			end
			prev_mark = (c == MARK);
			line_q.push_back(c);
		end
		line_q.push_back(MARK);
		line_q.push_back(MARK);
	endtask

	// 8N1 on uart_rx_port starting right after a rising edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		int         i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			uart_rx_port <= bits[i];
			repeat (CLKS_PER_BIT) @(posedge sys_clk);
		end
	endtask

	task automatic send_stream();
		logic [7:0] b;
		@(posedge sys_clk);
		while (line_q.size() > 0) begin
			b = line_q.pop_front();
			model_rx_byte(b);
			send_byte(b);
		end
	endtask

	// decode one byte from uart_tx_port with mid-bit samples on falling edges
	task automatic receive_byte(output logic [7:0] b);
		int cycles;
		int i;
		cycles = 0;
		@(negedge sys_clk);
		while (uart_tx_port) begin
			cycles++;
			if (cycles > 20 * CLKS_PER_BIT) timeout_abort("start bit on uart_tx_port");
			@(negedge sys_clk);
		end
		repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
		assert (uart_tx_port == 1'b0) else flag_mismatch("start bit not low at mid-bit");
		for (i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
			b[i] = uart_tx_port;
		end
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		assert (uart_tx_port == 1'b1) else flag_mismatch("stop bit not high");
	endtask

	// busy stays high until a single tx_done
	task automatic watch_tx_busy(input int len);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > (len + 5) * 10 * CLKS_PER_BIT) timeout_abort("tx_done");
			if (tx_done) begin
				assert (!tx_busy) else flag_mismatch("tx_busy still high with tx_done");
				seen = 1'b1;
			end else begin
				assert (tx_busy) else flag_mismatch("tx_busy low before tx_done");
			end
		end
	endtask

	task automatic check_tx_idle(input int n);
		repeat (n) begin
			@(negedge sys_clk);
			assert (uart_tx_port && !tx_busy && !tx_done)
				else flag_mismatch("transmit side active after tx_done");
		end
	endtask

	task automatic run_tx_frame(input int len);
		logic [SW-1:0] str;
		logic [7:0]    expect_q[$];
		logic [7:0]    got;
		int            i;
		int            j;
		str = '0;
		for (i = 0; i < len; i++) begin
			str[i*8 +: 8] = 8'(random_bits(8));
		end
		expect_q.push_back(MARK);
		expect_q.push_back(MARK);
		for (i = 0; i < len; i++) begin
			expect_q.push_back(str[i*8 +: 8]);
		end
		expect_q.push_back(MARK);
		expect_q.push_back(MARK);
		@(posedge sys_clk);
		tx_string <= str;
		tx_length <= 8'(len);
		tx_req    <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		fork
			begin
				for (j = 0; j < expect_q.size(); j++) begin
					receive_byte(got);
					assert (got == expect_q[j]) else flag_mismatch($sformatf(
						"tx byte %0d is %02h, expected %02h", j, got, expect_q[j]));
				end
			end
			watch_tx_busy(len);
			begin
				// second request in the middle of the frame
				repeat (40) @(posedge sys_clk);
				tx_req <= 1'b1;
				@(posedge sys_clk);
				tx_req <= 1'b0;
			end
		join
		check_tx_idle(20 * CLKS_PER_BIT);
	endtask

	task automatic check_rx_outputs();
		bit            kind;
		int            len;
		logic [SW-1:0] str;
		if (rx_done || rx_err) begin
			assert (exp_kind.size() > 0) else flag_mismatch("rx_done or rx_err not expected");
			assert (prev_rx_busy && !rx_busy)
				else flag_mismatch("rx_busy not high until rx_done or rx_err");
			kind = exp_kind.pop_front();
			len = exp_len.pop_front();
			str = exp_str.pop_front();
			if (kind) begin
				assert (rx_done && !rx_err) else flag_mismatch("expected rx_done only");
				assert (int'(rx_length) == len) else flag_mismatch($sformatf(
					"rx_length is %0d, expected %0d", rx_length, len));
				assert (lanes_match(rx_string, str, len))
					else flag_mismatch("rx_string mismatch");
				last_len = len;
				last_str = str;
			end else begin
				assert (rx_err && !rx_done) else flag_mismatch("expected rx_err only");
			end
		end
		if (!rx_done) begin
			assert (int'(rx_length) == last_len && lanes_match(rx_string, last_str, last_len))
				else flag_mismatch("rx_string or rx_length changed without rx_done");
		end
		prev_rx_busy = rx_busy;
	endtask

	always @(negedge sys_clk) begin
		if (sys_rst_n) check_rx_outputs();
	end

	task automatic wait_rx_drain(input int limit);
		int cycles;
		cycles = 0;
		while (exp_kind.size() > 0) begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > limit) timeout_abort("expected rx_done or rx_err");
		end
		@(negedge sys_clk);
		assert (!rx_busy) else flag_mismatch("rx_busy high after the stream ended");
	endtask

	initial begin
		sys_rst_n    = 1'b0;
		tx_string    = '0;
		tx_length    = '0;
		tx_req       = 1'b0;
		uart_rx_port = 1'b1;
		repeat (8) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		assert (uart_tx_port === 1'b1 && tx_busy === 1'b0 && tx_done === 1'b0 &&
			rx_busy === 1'b0 && rx_done === 1'b0 && rx_err === 1'b0)
			else flag_mismatch("outputs not in reset state");

		// transmit framing with the empty and the full string first
		run_tx_frame(0);
		run_tx_frame(MAX_CHARS);
		repeat (3) run_tx_frame(int'(random_bits(5)) % (MAX_CHARS + 1));

		// receive framing with hunting garbage in between
		add_frame(0);
		repeat (5) begin
			add_garbage();
			add_frame(int'(random_bits(5)) % (MAX_CHARS + 1));
		end
		send_stream();
		wait_rx_drain(10 * CLKS_PER_BIT);

		// overflow frame whose closing pair reopens a frame that a bare pair closes
		add_frame(MAX_CHARS + 1 + int'(random_bits(2)));
		line_q.push_back(MARK);
		line_q.push_back(MARK);
		add_frame(int'(random_bits(5)) % (MAX_CHARS + 1));
		send_stream();
		wait_rx_drain(10 * CLKS_PER_BIT);

		// both directions at once
		add_garbage();
		add_frame(MAX_CHARS);
		fork
			run_tx_frame(int'(random_bits(5)) % (MAX_CHARS + 1));
			send_stream();
		join
		wait_rx_drain(10 * CLKS_PER_BIT);

		repeat (10 * CLKS_PER_BIT) @(negedge sys_clk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* uart_string_top.sv */
// uart string transceiver top level
// framing sequencer and parser on a full duplex 8N1 link
module uart_string_top
	import uart_frame_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16,
	parameter int MAX_CHARS    = 16
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic [MAX_CHARS*8-1:0] tx_string,
	input  len_t                   tx_length,
	input  logic                   tx_req,
	output logic                   tx_busy,
	output logic                   tx_done,
	output logic [MAX_CHARS*8-1:0] rx_string,
	output len_t                   rx_length,
	output logic                   rx_busy,
	output logic                   rx_done,
	output logic                   rx_err,
	input  logic                   uart_rx_port,
	output logic                   uart_tx_port
);

	byte_t rx_byte;
	logic  rx_byte_valid;

	uart_byte_if i_tx_bus ();

	// transmit direction
	frame_tx_fsm #(
		.MAX_CHARS (MAX_CHARS)
	) i_frame_tx_fsm (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.bus       (i_tx_bus.ctrl)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (i_tx_bus.ser),
		.tx        (uart_tx_port)
	);

	// receive direction
	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx            (uart_rx_port),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	frame_rx_parser #(
		.MAX_CHARS (MAX_CHARS)
	) i_frame_rx_parser (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_busy       (rx_busy),
		.rx_done       (rx_done),
		.rx_err        (rx_err)
	);

endmodule

/* uart_tx.sv */
// 8N1 serializer
// latches a byte on start, then sends start bit, eight data bits lsb
// first and the stop bit, one per bit tick
module uart_tx
	import uart_frame_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	uart_byte_if.ser bus,
	output logic     tx
);

	uart_bit_state_t state;
	byte_t           shreg;
	logic [2:0]      bit_idx;
	logic            tick;

	baud_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_baud_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (state != BIT_IDLE),
		.half      (1'b0),
		.tick      (tick)
	);

	// busy follows the state, so it drops together with done
	assign bus.busy = (state != BIT_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= BIT_IDLE;
			bit_idx  <= '0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= 1'b0;
			case (state)
				BIT_IDLE: if (bus.start) state <= BIT_START;
				BIT_START: begin
					if (tick) begin
						state   <= BIT_DATA;
						bit_idx <= '0;
					end
				end
				BIT_DATA: begin
					if (tick) begin
						if (bit_idx == 3'd7) state <= BIT_STOP;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				BIT_STOP: begin
					if (tick) begin
						state    <= BIT_IDLE;
						bus.done <= 1'b1;
					end
				end
				default: state <= BIT_IDLE;
			endcase
		end
	end

	// shift register, lsb goes out first
	always_ff @(posedge sys_clk) begin
		if (state == BIT_IDLE && bus.start) begin
			shreg <= bus.data;
		end else if (state == BIT_DATA && tick) begin
			shreg <= shreg >> 1;
		end
	end

	always_comb begin
		case (state)
			BIT_START: tx = 1'b0;
			BIT_DATA:  tx = shreg[0];
			default:   tx = 1'b1;
		endcase
	end

	// the sequencer must wait for the previous byte to finish
	a_start_when_idle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		bus.start |-> !bus.busy
	) else $error("uart_tx start while busy");

endmodule
